/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_fetch_front_end -f flist.f -Mdir obj_dir
	./obj_dir/Vtb_fetch_front_end

clean:
	rm -rf obj_dir

/* flist.f */
src/fetch_pkg.sv
src/fetch_rsp_if.sv
src/fetch_sequencer.sv
src/ahb_fetch_master.sv
src/fetch_queue.sv
src/rv32i_predecoder.sv
src/fetch_front_end.sv
verif/fetch_front_end_assert.sv
verif/tb_fetch_front_end.sv

/* src/ahb_fetch_master.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_fetch_master (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               i_req,
    input  fetch_pkg::addr_t   i_req_addr,
    input  logic               i_flush,
    output logic               o_addr_free,
    fetch_rsp_if.master        rsp,
    output fetch_pkg::addr_t   o_haddr,
    output fetch_pkg::htrans_t o_htrans,
    input  fetch_pkg::instr_t  i_hrdata,
    input  logic               i_hready,
    input  logic               i_hresp
);
    import fetch_pkg::*;

    logic  ap_valid;     // Address phase on the bus
    logic  ap_discard;   // Flushed while in address phase
    addr_t ap_addr;
    logic  dp_valid;     // Data phase pending
    logic  dp_discard;
    addr_t dp_addr;

    // Free when idle or when the current address phase is accepted now
    assign o_addr_free = !ap_valid || i_hready;

    assign o_haddr  = ap_addr;
    assign o_htrans = ap_valid ? HTRANS_NONSEQ : HTRANS_IDLE;

    assign rsp.beat_done = dp_valid && i_hready;                          // Kept or not
    assign rsp.rsp_valid = rsp.beat_done && !dp_discard && !i_flush;
    assign rsp.rsp_pc    = dp_addr;
    assign rsp.rsp_instr = i_hresp ? '0 : i_hrdata;                       // No data on error
    assign rsp.rsp_fault = i_hresp;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ap_valid   <= 1'b0;
            ap_discard <= 1'b0;
            ap_addr    <= '0;
            dp_valid   <= 1'b0;
            dp_discard <= 1'b0;
        end else begin
            // Data phase: refilled from address phase on HREADY
            if (i_hready) begin
                dp_valid   <= ap_valid;
                dp_discard <= ap_discard || i_flush;
            end else begin
                dp_discard <= dp_discard || i_flush;   // Wait state, keep the beat
            end

            // Address phase
            if (i_req) begin
                ap_valid   <= 1'b1;
                ap_discard <= 1'b0;                  // Never requested during flush
                ap_addr    <= i_req_addr;
            end else if (i_hready) begin
                ap_valid   <= 1'b0;                  // Accepted, go IDLE
                ap_discard <= 1'b0;
            end else begin
                ap_discard <= ap_discard || i_flush; // Held by wait state
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_hready) begin
            dp_addr <= ap_addr;                      // Follows the beat
        end
    end

endmodule

`default_nettype wire

/* src/fetch_front_end.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front_end #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'h0000_0000,
    parameter int               QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 i_redirect,
    input  fetch_pkg::addr_t     i_redirect_pc,
    input  logic                 i_hold,
    output fetch_pkg::addr_t     o_haddr,
    output fetch_pkg::htrans_t   o_htrans,
    output fetch_pkg::hsize_t    o_hsize,
    output logic                 o_hwrite,
    input  fetch_pkg::instr_t    i_hrdata,
    input  logic                 i_hready,
    input  logic                 i_hresp,
    output logic                 o_dec_valid,
    output fetch_pkg::addr_t     o_dec_pc,
    output fetch_pkg::op_class_t o_dec_class,
    output fetch_pkg::reg_idx_t  o_dec_rd,
    output fetch_pkg::reg_idx_t  o_dec_rs1,
    output fetch_pkg::reg_idx_t  o_dec_rs2,
    output fetch_pkg::imm_t      o_dec_imm,
    output logic                 o_dec_fault
);
    import fetch_pkg::*;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic             req;
    addr_t            req_addr;
    logic             addr_free;
    logic             flush;
    logic [CNT_W-1:0] queue_count;
    addr_t            head_pc;
    instr_t           head_instr;
    logic             head_fault;
    logic             pop;
    logic             dec_hold;

    fetch_rsp_if u_rsp_if ();

    assign o_hsize  = HSIZE_WORD;   // Word fetches only
    assign o_hwrite = 1'b0;         // Read-only master
    assign dec_hold = i_hold || flush;   // No pop of stale head on redirect

    fetch_sequencer #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_sequencer (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_addr_free   (addr_free),
        .i_queue_count (queue_count),
        .rsp           (u_rsp_if),
        .o_req         (req),
        .o_req_addr    (req_addr),
        .o_flush       (flush)
    );

    ahb_fetch_master u_master (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_req       (req),
        .i_req_addr  (req_addr),
        .i_flush     (flush),
        .o_addr_free (addr_free),
        .rsp         (u_rsp_if),
        .o_haddr     (o_haddr),
        .o_htrans    (o_htrans),
        .i_hrdata    (i_hrdata),
        .i_hready    (i_hready),
        .i_hresp     (i_hresp)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .reset_n      (reset_n),
        .rsp          (u_rsp_if),
        .i_flush      (flush),
        .i_pop        (pop),
        .o_count      (queue_count),
        .o_head_pc    (head_pc),
        .o_head_instr (head_instr),
        .o_head_fault (head_fault)
    );

    rv32i_predecoder #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_predecoder (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_hold       (dec_hold),
        .i_count      (queue_count),
        .i_head_pc    (head_pc),
        .i_head_instr (head_instr),
        .i_head_fault (head_fault),
        .o_pop        (pop),
        .o_dec_valid  (o_dec_valid),
        .o_dec_pc     (o_dec_pc),
        .o_dec_class  (o_dec_class),
        .o_dec_rd     (o_dec_rd),
        .o_dec_rs1    (o_dec_rs1),
        .o_dec_rs2    (o_dec_rs2),
        .o_dec_imm    (o_dec_imm),
        .o_dec_fault  (o_dec_fault)
    );

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;       // Byte address, PC and HADDR
    typedef logic [31:0] instr_t;      // Raw instruction word
    typedef logic [31:0] imm_t;        // Sign-extended immediate
    typedef logic [4:0]  reg_idx_t;    // x0..x31
    typedef logic [6:0]  opcode_t;     // Bits 6:0 of the word
    typedef logic [2:0]  op_class_t;   // Predecoded class
    typedef logic [1:0]  htrans_t;     // AHB HTRANS
    typedef logic [2:0]  hsize_t;      // AHB HSIZE

    // Instruction classes
    localparam op_class_t CLASS_ALU     = 3'd0;  // R-type
    localparam op_class_t CLASS_ALU_IMM = 3'd1;  // I-type arithmetic
    localparam op_class_t CLASS_LOAD    = 3'd2;
    localparam op_class_t CLASS_STORE   = 3'd3;
    localparam op_class_t CLASS_BRANCH  = 3'd4;
    localparam op_class_t CLASS_JUMP    = 3'd5;  // JAL and JALR
    localparam op_class_t CLASS_UPPER   = 3'd6;  // LUI and AUIPC
    localparam op_class_t CLASS_OTHER   = 3'd7;  // FENCE, SYSTEM, unknown

    // RV32I base opcode map
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // AHB-Lite encodings
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam hsize_t  HSIZE_WORD    = 3'b010;  // 32-bit beat

endpackage

`default_nettype wire

/* src/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             reset_n,
    fetch_rsp_if.queue                       rsp,
    input  logic                             i_flush,
    input  logic                             i_pop,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] o_count,
    output fetch_pkg::addr_t                 o_head_pc,
    output fetch_pkg::instr_t                o_head_instr,
    output logic                             o_head_fault
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);   // Wraps naturally, power of two
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    addr_t            pc_mem    [QUEUE_DEPTH];
    instr_t           instr_mem [QUEUE_DEPTH];
    logic             fault_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign o_count      = count;
    assign o_head_pc    = pc_mem[rd_ptr];
    assign o_head_instr = instr_mem[rd_ptr];
    assign o_head_fault = fault_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rsp.rsp_valid) begin
            pc_mem[wr_ptr]    <= rsp.rsp_pc;
            instr_mem[wr_ptr] <= rsp.rsp_instr;
            fault_mem[wr_ptr] <= rsp.rsp_fault;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;                            // Drops a same-cycle push too
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rsp.rsp_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({rsp.rsp_valid, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/fetch_rsp_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fetch_rsp_if;
    import fetch_pkg::*;

    logic   rsp_valid;   // Beat kept, one-cycle strobe
    addr_t  rsp_pc;      // Address of the returned word
    instr_t rsp_instr;   // Zero on bus error
    logic   rsp_fault;   // HRESP error seen
    logic   beat_done;   // Any data phase finished, kept or discarded

    modport master (
        output rsp_valid, rsp_pc, rsp_instr, rsp_fault, beat_done
    );

    modport queue (
        input rsp_valid, rsp_pc, rsp_instr, rsp_fault
    );

    modport seq (
        input beat_done
    );

endinterface

`default_nettype wire

/* src/fetch_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'h0000_0000,
    parameter int               QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             i_redirect,
    input  fetch_pkg::addr_t                 i_redirect_pc,
    input  logic                             i_addr_free,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0] i_queue_count,
    fetch_rsp_if.seq                         rsp,
    output logic                             o_req,
    output fetch_pkg::addr_t                 o_req_addr,
    output logic                             o_flush
);
    import fetch_pkg::*;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    addr_t            pc;          // Next word to fetch
    logic [CNT_W-1:0] in_flight;   // Beats issued, data phase not yet done
    logic [CNT_W:0]   used;        // Queue slots already claimed

    assign used       = {1'b0, i_queue_count} + {1'b0, in_flight};
    assign o_req      = i_addr_free && !i_redirect && (used < (CNT_W+1)'(QUEUE_DEPTH));
    assign o_req_addr = pc;
    assign o_flush    = i_redirect;   // Queue empties on the same edge as the PC reload

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= RESET_PC;
        end else if (i_redirect) begin
            pc <= i_redirect_pc;         // New target
        end else if (o_req) begin
            pc <= pc + 32'd4;            // Sequential fetch
        end
    end

    // Discarded beats still hold a slot until their data phase ends
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_flight <= '0;
        end else begin
            case ({o_req, rsp.beat_done})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;   // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/rv32i_predecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_predecoder #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             i_hold,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0] i_count,
    input  fetch_pkg::addr_t                 i_head_pc,
    input  fetch_pkg::instr_t                i_head_instr,
    input  logic                             i_head_fault,
    output logic                             o_pop,
    output logic                             o_dec_valid,
    output fetch_pkg::addr_t                 o_dec_pc,
    output fetch_pkg::op_class_t             o_dec_class,
    output fetch_pkg::reg_idx_t              o_dec_rd,
    output fetch_pkg::reg_idx_t              o_dec_rs1,
    output fetch_pkg::reg_idx_t              o_dec_rs2,
    output fetch_pkg::imm_t                  o_dec_imm,
    output logic                             o_dec_fault
);
    import fetch_pkg::*;

    opcode_t   opcode;
    op_class_t cls;
    imm_t      imm;

    assign opcode = i_head_instr[6:0];
    assign o_pop  = (i_count != '0) && !i_hold;   // Take head when present

    always_comb begin
        case (opcode)
            OPC_OP:              cls = CLASS_ALU;
            OPC_OP_IMM:          cls = CLASS_ALU_IMM;
            OPC_LOAD:            cls = CLASS_LOAD;
            OPC_STORE:           cls = CLASS_STORE;
            OPC_BRANCH:          cls = CLASS_BRANCH;
            OPC_JAL, OPC_JALR:   cls = CLASS_JUMP;
            OPC_LUI, OPC_AUIPC:  cls = CLASS_UPPER;
            default:             cls = CLASS_OTHER;   // Faulted words land here
        endcase
    end

    // Immediate by format
    always_comb begin
        case (cls)
            CLASS_ALU_IMM, CLASS_LOAD:
                imm = {{20{i_head_instr[31]}}, i_head_instr[31:20]};             // I
            CLASS_STORE:
                imm = {{20{i_head_instr[31]}}, i_head_instr[31:25], i_head_instr[11:7]};
            CLASS_BRANCH:
                imm = {{19{i_head_instr[31]}}, i_head_instr[31], i_head_instr[7],
                       i_head_instr[30:25], i_head_instr[11:8], 1'b0};         // B
            CLASS_UPPER:
                imm = {i_head_instr[31:12], 12'h000};                          // U
            CLASS_JUMP:
                if (opcode == OPC_JALR) begin
                    imm = {{20{i_head_instr[31]}}, i_head_instr[31:20]};         // JALR is I
                end else begin
                    imm = {{11{i_head_instr[31]}}, i_head_instr[31], i_head_instr[19:12],
                           i_head_instr[20], i_head_instr[30:21], 1'b0};       // J
                end
            default:
                imm = '0;                                                      // ALU, OTHER
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_dec_valid <= 1'b0;
        end else begin
            o_dec_valid <= o_pop;   // One cycle after pop
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_dec_pc    <= i_head_pc;
            o_dec_class <= cls;
            o_dec_rd    <= i_head_instr[11:7];
            o_dec_rs1   <= i_head_instr[19:15];
            o_dec_rs2   <= i_head_instr[24:20];
            o_dec_imm   <= imm;
            o_dec_fault <= i_head_fault;
        end
    end

endmodule

`default_nettype wire

/* verif/fetch_front_end_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front_end_assert (
    input logic               clk,
    input logic               reset_n,
    input logic               i_hold,
    input fetch_pkg::htrans_t i_htrans,
    input fetch_pkg::addr_t   i_haddr,
    input logic               i_hready,
    input logic               i_dec_valid
);
    import fetch_pkg::*;

    // Bus quiet while reset is applied
    idle_in_reset: assert property (@(posedge clk) !reset_n |-> i_htrans == HTRANS_IDLE)
        else $error("HTRANS not IDLE during reset");

    // Wait state holds the address phase and its address
    addr_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (i_htrans == HTRANS_NONSEQ && !i_hready) |=>
            (i_htrans == HTRANS_NONSEQ && $stable(i_haddr)))
        else $error("HADDR changed during a stalled address phase");

    // No pop while held, so no decoded output a cycle later
    hold_blocks_decode: assert property (@(posedge clk) disable iff (!reset_n)
        i_hold |=> !i_dec_valid)
        else $error("Decoded output one cycle after hold was high");

endmodule

bind fetch_front_end fetch_front_end_assert u_assert (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_hold      (i_hold),
    .i_htrans    (o_htrans),
    .i_haddr     (o_haddr),
    .i_hready    (i_hready),
    .i_dec_valid (o_dec_valid)
);

`default_nettype wire

/* verif/tb_fetch_front_end.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_front_end;
    import fetch_pkg::*;

    localparam addr_t RESET_PC = 32'h0000_1000;
    localparam addr_t FAULT_LO = 32'h0000_1040;   // Four words answer with ERROR
    localparam addr_t FAULT_HI = 32'h0000_104C;

    typedef struct packed {
        op_class_t cls;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        imm_t      imm;
    } dec_t;

    logic      clk           = 1'b0;
    logic      reset_n       = 1'b0;
    logic      i_redirect    = 1'b0;
    addr_t     i_redirect_pc = '0;
    logic      i_hold        = 1'b0;
    instr_t    i_hrdata      = '0;
    logic      i_hready      = 1'b1;
    logic      i_hresp       = 1'b0;
    addr_t     o_haddr;
    htrans_t   o_htrans;
    hsize_t    o_hsize;
    logic      o_hwrite;
    logic      o_dec_valid;
    addr_t     o_dec_pc;
    op_class_t o_dec_class;
    reg_idx_t  o_dec_rd;
    reg_idx_t  o_dec_rs1;
    reg_idx_t  o_dec_rs2;
    imm_t      o_dec_imm;
    logic      o_dec_fault;

    integer seed       = 30275;
    int     hold_mode  = 0;          // 0 low, 1 random, 2 high
    int     n_decoded  = 0;
    int     n_faults   = 0;
    addr_t  exp_pc     = RESET_PC;   // Next PC the decoder must show
    logic   s_dp_valid = 1'b0;       // Slave side data phase
    addr_t  s_dp_addr  = '0;
    logic   err_second = 1'b0;       // Second cycle of ERROR

    fetch_front_end #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(4)) dut (.*);

    always #5 clk = ~clk;

    // Memory contents cycle through every opcode as the PC advances
    function automatic instr_t mem_hash(input addr_t a);
        logic [31:0] h;
        logic [6:0]  opc;
        h = (a ^ 32'h5A5A_1234) * 32'h9E37_79B1;
        h = h ^ (h >> 13);
        case (a[5:2])
            4'd0, 4'd12: opc = 7'b0110011;   // R
            4'd1, 4'd11: opc = 7'b0010011;   // I arith
            4'd2, 4'd14: opc = 7'b0000011;   // Load
            4'd3, 4'd15: opc = 7'b0100011;   // Store
            4'd4, 4'd13: opc = 7'b1100011;   // Branch
            4'd5:        opc = 7'b1101111;   // JAL
            4'd6:        opc = 7'b1100111;   // JALR
            4'd7:        opc = 7'b0110111;   // LUI
            4'd8:        opc = 7'b0010111;   // AUIPC
            4'd9:        opc = 7'b1110011;   // SYSTEM
            default:     opc = 7'b0001111;   // FENCE
        endcase
        return {h[31:7], opc};
    endfunction

    function automatic logic in_fault(input addr_t a);
        return (a >= FAULT_LO) && (a <= FAULT_HI);
    endfunction

    // Expected predecode straight from the RV32I encoding tables
    function automatic dec_t ref_decode(input instr_t w);
        dec_t d;
        d.rd  = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        case (w[6:0])
            7'b0110011:             d.cls = CLASS_ALU;
            7'b0010011:             d.cls = CLASS_ALU_IMM;
            7'b0000011:             d.cls = CLASS_LOAD;
            7'b0100011:             d.cls = CLASS_STORE;
            7'b1100011:             d.cls = CLASS_BRANCH;
            7'b1101111, 7'b1100111: d.cls = CLASS_JUMP;
            7'b0110111, 7'b0010111: d.cls = CLASS_UPPER;
            default:                d.cls = CLASS_OTHER;
        endcase
        case (w[6:0])
            7'b0010011, 7'b0000011, 7'b1100111: d.imm = {{20{w[31]}}, w[31:20]};
            7'b0100011: d.imm = {{20{w[31]}}, w[31:25], w[11:7]};                // S
            7'b1100011: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};    // B
            7'b0110111, 7'b0010111: d.imm = {w[31:12], 12'h000};                 // U
            7'b1101111: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};  // J
            default:    d.imm = '0;
        endcase
        return d;
    endfunction

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            $display("Mismatch %s: expected %h, actual %h", name, want, got);
            $display("Something failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic wait_decodes(input int count, input int limit);
        int target;
        int cycles;
        target = n_decoded + count;
        cycles = 0;
        while (n_decoded < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: %0d of %0d instructions not decoded", target - n_decoded,
                         count);
                $display("Something failed");
                $fatal(1, "Decode timeout");
            end
        end
        @(negedge clk);
    endtask

    task automatic set_hold(input int mode);
        @(posedge clk);
        hold_mode = mode;   // Picked up by the driver at the next falling edge
        @(negedge clk);
    endtask

    task automatic redirect_to(input addr_t pc);
        i_redirect    = 1'b1;
        i_redirect_pc = pc;
        @(negedge clk);
        i_redirect    = 1'b0;
    endtask

    // Slave moves the beat into its data phase on HREADY
    always @(posedge clk) begin
        if (!reset_n) begin
            s_dp_valid <= 1'b0;
        end else if (i_hready) begin
            s_dp_valid <= (o_htrans == HTRANS_NONSEQ);
            s_dp_addr  <= o_haddr;
        end
    end

    // Falling edge driver for the AHB response and the hold input
    always @(negedge clk) begin
        if (!s_dp_valid) begin
            i_hready <= 1'b1;                        // Idle bus answers with zero wait
            i_hresp  <= 1'b0;
        end else if (in_fault(s_dp_addr)) begin
            i_hresp    <= 1'b1;
            i_hready   <= err_second;                // Low then high
            err_second <= !err_second;
        end else begin
            i_hresp  <= 1'b0;
            i_hrdata <= mem_hash(s_dp_addr);
            i_hready <= (($random(seed) & 3) != 0);  // Roughly one wait in four
        end
        case (hold_mode)
            1:       i_hold <= (($random(seed) & 3) == 0);
            2:       i_hold <= 1'b1;
            default: i_hold <= 1'b0;
        endcase
    end

    // Redirect sampled on the rising edge and outputs on the falling edge
    always begin
        dec_t   want;
        instr_t word;
        logic   fault;
        @(posedge clk);
        if (i_redirect) begin
            exp_pc = i_redirect_pc;
        end
        @(negedge clk);
        if (reset_n && o_dec_valid) begin
            fault = in_fault(exp_pc);
            word  = fault ? '0 : mem_hash(exp_pc);   // ERROR beats carry no data
            want  = ref_decode(word);
            check_value("dec_pc", exp_pc, o_dec_pc);
            check_value("dec_class", 32'(want.cls), 32'(o_dec_class));
            check_value("dec_rd", 32'(want.rd), 32'(o_dec_rd));
            check_value("dec_rs1", 32'(want.rs1), 32'(o_dec_rs1));
            check_value("dec_rs2", 32'(want.rs2), 32'(o_dec_rs2));
            check_value("dec_imm", want.imm, o_dec_imm);
            check_value("dec_fault", 32'(fault), 32'(o_dec_fault));
            if (fault) begin
                n_faults++;
            end
            n_decoded++;
            exp_pc = exp_pc + 32'd4;
        end
    end

    initial begin
        reset_n       = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        check_value("hsize", 32'd2, 32'(o_hsize));   // Word beat per AHB
        check_value("hwrite", 32'd0, 32'(o_hwrite));
        wait_decodes(24, 500);                       // Crosses the fault window
        set_hold(2);
        repeat (40) @(negedge clk);                  // Queue fills and credits run out
        check_value("htrans_on_hold", 32'(HTRANS_IDLE), 32'(o_htrans));
        set_hold(1);
        wait_decodes(20, 800);
        redirect_to(32'h0000_2000);
        wait_decodes(16, 600);
        redirect_to(32'h0000_1038);                  // Back across the fault window
        wait_decodes(12, 600);
        set_hold(0);
        redirect_to(32'h0000_3000);
        wait_decodes(8, 400);
        check_value("faults_seen", 32'd8, 32'(n_faults));
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
